// File: cache/dm_cache.sv
`timescale 1ns/1ns
`default_nettype none

module dm_cache import dmem_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  word_addr_t daddr,
    input  logic       rd_req,
    input  logic       wr_req,
    input  word_t      wdata,
    output word_t      rd_word,
    output logic       nstall,
    // writeback
    output line_addr_t wb_addr,
    output line_t      wb_data,
    output logic       wb_valid,
    input  logic       wb_ready,
    // refill address
    output line_addr_t rf_addr,
    output logic       rf_avalid,
    input  logic       rf_aready,
    // refill data
    input  line_t      rf_data,
    input  logic       rf_dvalid,
    output logic       rf_dready
);

    tag_t    tag;
    index_t  index;
    offset_t offset;

    tag_t                     tag_arr [1 << INDEX_W];
    logic [(1 << INDEX_W)-1:0] valid_q;

    cache_state_e state;
    cache_state_e state_next;

    line_t                     rd_line;
    line_t                     wr_line;
    logic [WORDS_PER_LINE-1:0] wen;
    offset_t                   offset_q;
    logic                      rd_fire_q;

    logic req;
    logic hit;
    logic refill_done;

    assign {tag, index, offset} = daddr[TAG_W+INDEX_W+OFFSET_W-1:0];

    assign req         = rd_req || wr_req;
    assign hit         = valid_q[index] && (tag_arr[index] == tag);
    assign nstall      = !(req && !hit);
    assign refill_done = (state == RF_WAIT) && rf_dvalid;

    // line addresses are 16-byte aligned
    assign wb_addr = {tag_arr[index], index, {(OFFSET_W + 2){1'b0}}};
    assign rf_addr = {tag, index, {(OFFSET_W + 2){1'b0}}};

    // victim line is the registered read of the held index
    assign wb_data = rd_line;

    assign wb_valid  = state == WB_REQ;
    assign rf_avalid = state == RF_REQ;
    assign rf_dready = state == RF_WAIT;

    always_comb begin
        if (refill_done) begin
            wen     = '1;
            wr_line = rf_data;
        end else begin
            wen     = (wr_req && hit) ? WORDS_PER_LINE'(1) << offset : '0;
            wr_line = {WORDS_PER_LINE{wdata}};
        end
    end

    line_store i_line_store (
        .clk     (clk),
        .index   (index),
        .wen     (wen),
        .wr_line (wr_line),
        .rd_line (rd_line)
    );

    // word select lines up with the registered line read
    always_ff @(posedge clk) begin
        offset_q <= offset;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_fire_q <= 1'b0;
        end else begin
            rd_fire_q <= rd_req && hit;
        end
    end

    // zero between reads
    assign rd_word = rd_fire_q ? rd_line[offset_q*WORD_W +: WORD_W] : '0;

    always_ff @(posedge clk) begin
        if (refill_done) begin
            tag_arr[index] <= tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (refill_done) begin
            valid_q[index] <= 1'b1;
        end
    end

    // blocking miss controller, one miss at a time
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (req && !hit) begin
                    // no dirty bits, any valid victim goes back
                    state_next = valid_q[index] ? WB_REQ : RF_REQ;
                end
            end
            WB_REQ: begin
                if (wb_ready) begin
                    state_next = RF_REQ;
                end
            end
            RF_REQ: begin
                if (rf_aready) begin
                    state_next = RF_WAIT;
                end
            end
            RF_WAIT: begin
                if (rf_dvalid) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

// File: cache/line_store.sv
`timescale 1ns/1ns
`default_nettype none

module line_store import dmem_pkg::*; (
    input  logic       clk,
    input  index_t     index,
    input  logic [3:0] wen,
    input  line_t      wr_line,
    output line_t      rd_line
);

    // one bank per word of the line
    for (genvar w = 0; w < WORDS_PER_LINE; w++) begin : g_bank
        word_t bank [1 << INDEX_W];
        word_t rd_q;

        // read returns the old word on a same-cycle write
        always_ff @(posedge clk) begin
            if (wen[w]) begin
                bank[index] <= wr_line[w*WORD_W +: WORD_W];
            end
            rd_q <= bank[index];
        end

        assign rd_line[w*WORD_W +: WORD_W] = rd_q;
    end

endmodule

`default_nettype wire

// File: common/dmem_pkg.sv
`default_nettype none

package dmem_pkg;

    // core word address and its cache fields
    localparam int ADDR_W   = 30;
    localparam int TAG_W    = 13;
    localparam int INDEX_W  = 10;
    localparam int OFFSET_W = 2;

    // byte address of a line on the dram side
    localparam int LINE_ADDR_W = 27;

    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 1 << OFFSET_W;
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;

    // short bit time, simulation only
    localparam int UART_CLKS_PER_BIT = 8;
    localparam int UART_CNT_W        = $clog2(UART_CLKS_PER_BIT);

    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    typedef logic [ADDR_W-1:0]      word_addr_t;
    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [TAG_W-1:0]       tag_t;
    typedef logic [INDEX_W-1:0]     index_t;
    typedef logic [OFFSET_W-1:0]    offset_t;
    typedef logic [LINE_ADDR_W-1:0] line_addr_t;
    // word 0 sits in the low bits
    typedef logic [LINE_W-1:0]      line_t;
    typedef logic [7:0]             byte_t;

    // miss controller
    typedef enum logic [1:0] {
        IDLE,
        WB_REQ,
        RF_REQ,
        RF_WAIT
    } cache_state_e;

endpackage

`default_nettype wire

// File: design/byte_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module byte_fifo import dmem_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  byte_t wr_byte,
    input  logic  wr_en,
    input  logic  rd_en,
    output byte_t rd_byte,
    output logic  full,
    output logic  empty
);

    byte_t                 mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;
    logic                  do_wr;
    logic                  do_rd;

    assign full  = count == (FIFO_PTR_W + 1)'(FIFO_DEPTH);
    assign empty = count == '0;

    // blocked requests are dropped here
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // head is visible without a read cycle
    assign rd_byte = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_byte;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (FIFO_PTR_W + 1)'(do_wr) - (FIFO_PTR_W + 1)'(do_rd);
        end
    end

endmodule

`default_nettype wire

// File: design/dmem_unit.sv
`timescale 1ns/1ns
`default_nettype none

module dmem_unit import dmem_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  word_addr_t daddr,
    input  logic       mre,
    input  logic       mwe,
    input  word_t      wdata,
    output word_t      rdata,
    input  logic       rxd,
    output logic       txd,
    output logic       rx_valid,
    output logic       tx_ready,
    output logic       uart_nstall,
    output logic       cache_nstall,
    output line_addr_t wb_addr,
    output line_t      wb_data,
    output logic       wb_valid,
    input  logic       wb_ready,
    output line_addr_t rf_addr,
    output logic       rf_avalid,
    input  logic       rf_aready,
    input  line_t      rf_data,
    input  logic       rf_dvalid,
    output logic       rf_dready
);

    logic  uart_sel;
    logic  cache_sel;
    byte_t rx_byte;
    logic  rx_strobe;
    byte_t rx_head;
    logic  rx_empty;
    logic  rx_pop;
    byte_t tx_head;
    logic  tx_full;
    logic  tx_empty;
    logic  tx_push;
    logic  tx_idle;
    logic  tx_start;
    logic  uart_sel_q;
    byte_t byte_q;
    word_t cache_word;

    // address zero is the uart, the low window is cached
    assign uart_sel  = daddr == '0;
    assign cache_sel = (daddr[ADDR_W-1:TAG_W+INDEX_W+OFFSET_W] == '0) && !uart_sel;

    assign uart_nstall = !(uart_sel && ((mre && rx_empty) || (mwe && tx_full)));

    assign rx_pop   = uart_sel && mre && !rx_empty;
    assign tx_push  = uart_sel && mwe && !tx_full;
    assign tx_start = !tx_empty && tx_idle;

    assign rx_valid = !rx_empty;
    assign tx_ready = !tx_full;

    uart_rx i_uart_rx (
        .clk       (clk),
        .rst       (rst),
        .rxd       (rxd),
        .rx_byte   (rx_byte),
        .rx_strobe (rx_strobe)
    );

    // overflow drops the byte inside the queue
    byte_fifo fifo_rx (
        .clk     (clk),
        .rst     (rst),
        .wr_byte (rx_byte),
        .wr_en   (rx_strobe),
        .rd_en   (rx_pop),
        .rd_byte (rx_head),
        .full    (),
        .empty   (rx_empty)
    );

    byte_fifo fifo_tx (
        .clk     (clk),
        .rst     (rst),
        .wr_byte (wdata[7:0]),
        .wr_en   (tx_push),
        .rd_en   (tx_start),
        .rd_byte (tx_head),
        .full    (tx_full),
        .empty   (tx_empty)
    );

    uart_tx i_uart_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_byte  (tx_head),
        .tx_start (tx_start),
        .txd      (txd),
        .tx_ready (tx_idle)
    );

    dm_cache i_cache (
        .clk       (clk),
        .rst       (rst),
        .daddr     (daddr),
        .rd_req    (mre && cache_sel),
        .wr_req    (mwe && cache_sel),
        .wdata     (wdata),
        .rd_word   (cache_word),
        .nstall    (cache_nstall),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .wb_valid  (wb_valid),
        .wb_ready  (wb_ready),
        .rf_addr   (rf_addr),
        .rf_avalid (rf_avalid),
        .rf_aready (rf_aready),
        .rf_data   (rf_data),
        .rf_dvalid (rf_dvalid),
        .rf_dready (rf_dready)
    );

    // popped byte returns one cycle later like a cache word
    always_ff @(posedge clk) begin
        if (rx_pop) begin
            byte_q <= rx_head;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            uart_sel_q <= 1'b0;
        end else begin
            uart_sel_q <= rx_pop;
        end
    end

    assign rdata = uart_sel_q ? word_t'(byte_q) : cache_word;

endmodule

`default_nettype wire

// File: flist.f
common/dmem_pkg.sv
design/byte_fifo.sv
uart/uart_rx.sv
uart/uart_tx.sv
cache/line_store.sv
cache/dm_cache.sv
design/dmem_unit.sv
verif/tb_clock.sv
verif/line_mem_model.sv
verif/dmem_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the data-memory testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ns -j 0 \
    --top-module dmem_tb -Mdir obj_dir -f flist.f
./obj_dir/Vdmem_tb

// File: uart/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx import dmem_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  rxd,
    output byte_t rx_byte,
    output logic  rx_strobe
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e             state;
    logic                  rxd_meta;
    logic                  rxd_sync;
    logic [UART_CNT_W-1:0] clk_cnt;
    logic [2:0]            bit_cnt;
    byte_t                 shift;

    // two-flop synchronizer, line idles high
    always_ff @(posedge clk) begin
        if (rst) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= RX_IDLE;
            clk_cnt   <= '0;
            bit_cnt   <= '0;
            rx_strobe <= 1'b0;
        end else begin
            rx_strobe <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rxd_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // recheck start bit at its middle
                    if (clk_cnt == UART_CNT_W'(UART_CLKS_PER_BIT / 2 - 1)) begin
                        clk_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= rxd_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == UART_CNT_W'(UART_CLKS_PER_BIT - 1)) begin
                        clk_cnt <= '0;
                        // lsb arrives first
                        shift   <= {rxd_sync, shift[7:1]};
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (clk_cnt == UART_CNT_W'(UART_CLKS_PER_BIT - 1)) begin
                        // framing error drops the byte
                        if (rxd_sync) begin
                            rx_byte   <= shift;
                            rx_strobe <= 1'b1;
                        end
                        state <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: uart/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx import dmem_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  byte_t tx_byte,
    input  logic  tx_start,
    output logic  txd,
    output logic  tx_ready
);

    logic                  busy;
    logic [UART_CNT_W-1:0] clk_cnt;
    logic [3:0]            bit_cnt;
    // data bits with the stop bit on top
    logic [8:0]            frame;

    assign tx_ready = !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            txd     <= 1'b1;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (!busy) begin
            if (tx_start) begin
                busy    <= 1'b1;
                frame   <= {1'b1, tx_byte};
                // start bit goes out right away
                txd     <= 1'b0;
                clk_cnt <= '0;
                bit_cnt <= '0;
            end
        end else if (clk_cnt == UART_CNT_W'(UART_CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                // stop bit done, line stays high
                busy <= 1'b0;
            end else begin
                txd     <= frame[0];
                frame   <= frame >> 1;
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: verif/dmem_patterns.txt
// kind addr data: kind 1 writes data, kind 2 reads and expects data
// addr 0 is the uart (low byte only), fill of word k in line L is L + k
2 00000010 00000040
1 00000011 deadbeef
2 00000011 deadbeef
2 00000012 00000042
2 00001012 00004042
2 00000011 deadbeef
2 00000013 00000043
1 00001013 12345678
2 00001013 12345678
2 00001010 00004040
2 01ffffff 07fffff3
2 00000010 00000040
2 00001013 12345678
1 00000000 000000a5
2 00000000 000000a5
1 00000000 00000011
1 00000000 00000022
1 00000000 00000033
1 00000000 00000044
1 00000000 00000055
1 00000000 00000066
1 00000000 00000077
1 00000000 00000088
1 00000000 00000099
1 00000000 000000aa
2 00000000 00000011
2 00000000 00000022
2 00000000 00000033
2 00000000 00000044
2 00000000 00000055
2 00000000 00000066
2 00000000 00000077
2 00000000 00000088
2 00000000 00000099
2 00000000 000000aa

// File: verif/dmem_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dmem_tb import dmem_pkg::*; ();

    localparam int MAX_OPS    = 64;
    localparam int WORST_MISS = 64;
    localparam int FRAME_CLKS = 10 * UART_CLKS_PER_BIT + 8;

    logic       clk;
    logic       rst;
    word_addr_t daddr;
    logic       mre;
    logic       mwe;
    word_t      wdata;
    word_t      rdata;
    logic       serial;
    logic       rx_valid;
    logic       tx_ready;
    logic       uart_nstall;
    logic       cache_nstall;
    line_addr_t wb_addr;
    line_t      wb_data;
    logic       wb_valid;
    logic       wb_ready;
    line_addr_t rf_addr;
    logic       rf_avalid;
    logic       rf_aready;
    line_t      rf_data;
    logic       rf_dvalid;
    logic       rf_dready;

    // kind, address, data per operation
    word_t pat [3 * MAX_OPS];
    int    n_ops;
    int    cycle_limit = 0;
    int    cycles;

    // which tag each cache line should hold
    tag_t                      res_tag [1 << INDEX_W];
    logic [(1 << INDEX_W)-1:0] res_valid;

    tb_clock i_clock (
        .clk (clk)
    );

    line_mem_model i_mem (
        .clk       (clk),
        .rst       (rst),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .wb_valid  (wb_valid),
        .wb_ready  (wb_ready),
        .rf_addr   (rf_addr),
        .rf_avalid (rf_avalid),
        .rf_aready (rf_aready),
        .rf_data   (rf_data),
        .rf_dvalid (rf_dvalid),
        .rf_dready (rf_dready)
    );

    // txd loops straight back into rxd
    dmem_unit i_dut (
        .clk          (clk),
        .rst          (rst),
        .daddr        (daddr),
        .mre          (mre),
        .mwe          (mwe),
        .wdata        (wdata),
        .rdata        (rdata),
        .rxd          (serial),
        .txd          (serial),
        .rx_valid     (rx_valid),
        .tx_ready     (tx_ready),
        .uart_nstall  (uart_nstall),
        .cache_nstall (cache_nstall),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .wb_valid     (wb_valid),
        .wb_ready     (wb_ready),
        .rf_addr      (rf_addr),
        .rf_avalid    (rf_avalid),
        .rf_aready    (rf_aready),
        .rf_data      (rf_data),
        .rf_dvalid    (rf_dvalid),
        .rf_dready    (rf_dready)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic load_patterns();
        for (int k = 0; k < 3 * MAX_OPS; k++) begin
            pat[k] = '0;
        end
        $readmemh("verif/dmem_patterns.txt", pat);
        n_ops = 0;
        // kind zero ends the list
        while (n_ops < MAX_OPS && pat[3 * n_ops] != '0) begin
            n_ops++;
        end
        if (n_ops == 0) begin
            abort_run("pattern file holds no operations");
        end
        cycle_limit = n_ops * (WORST_MISS + FRAME_CLKS) * 2;
    endtask

    // kind 1 writes, kind 2 reads and checks
    task automatic run_op(input word_t kind, input word_addr_t addr, input word_t data);
        logic   is_uart;
        logic   cacheable;
        logic   exp_miss;
        logic   saw_cstall;
        index_t idx;
        tag_t   tag;
        is_uart   = addr == '0;
        cacheable = !is_uart && addr[ADDR_W-1:TAG_W+INDEX_W+OFFSET_W] == '0;
        idx       = addr[INDEX_W+OFFSET_W-1:OFFSET_W];
        tag       = addr[TAG_W+INDEX_W+OFFSET_W-1:INDEX_W+OFFSET_W];
        exp_miss  = cacheable && !(res_valid[idx] && res_tag[idx] == tag);
        saw_cstall = 1'b0;
        if (kind != 1 && kind != 2) begin
            abort_run($sformatf("unknown operation kind %0h in the pattern file", kind));
        end
        @(posedge clk);
        daddr <= addr;
        mre   <= kind == 2;
        mwe   <= kind == 1;
        wdata <= data;
        // hold until both stall levels are high
        do begin
            @(posedge clk);
            if (!cache_nstall) begin
                saw_cstall = 1'b1;
            end
            if (is_uart && kind == 2 && uart_nstall != rx_valid) begin
                abort_run("uart_nstall does not follow the receive queue on a read");
            end
            if (is_uart && kind == 1 && uart_nstall != tx_ready) begin
                abort_run("uart_nstall does not follow the transmit queue on a write");
            end
        end while (!(uart_nstall && cache_nstall));
        mre <= 1'b0;
        mwe <= 1'b0;
        if (exp_miss && !saw_cstall) begin
            abort_run($sformatf("cache_nstall never dropped on a miss at %h", addr));
        end
        if (!exp_miss && saw_cstall) begin
            abort_run($sformatf("cache_nstall dropped on a hit at %h", addr));
        end
        if (cacheable) begin
            res_valid[idx] = 1'b1;
            res_tag[idx]   = tag;
        end
        if (kind == 2) begin
            @(posedge clk);
            if (is_uart) begin
                check_byte("rdata[7:0]", rdata[7:0], data[7:0]);
                check_word("rdata", rdata, word_t'(data[7:0]));
            end else begin
                check_word("rdata", rdata, data);
            end
        end
    endtask

    initial begin
        rst   <= 1'b1;
        daddr <= '0;
        mre   <= 1'b0;
        mwe   <= 1'b0;
        wdata <= '0;
        res_valid = '0;
        load_patterns();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < n_ops; i++) begin
            run_op(pat[3 * i], word_addr_t'(pat[3 * i + 1]), pat[3 * i + 2]);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

    // limit scales with the pattern count
    initial begin
        cycles = 0;
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        abort_run($sformatf("timeout after %0d cycles", cycles));
    end

endmodule

`default_nettype wire

// File: verif/line_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module line_mem_model import dmem_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  line_addr_t wb_addr,
    input  line_t      wb_data,
    input  logic       wb_valid,
    output logic       wb_ready,
    input  line_addr_t rf_addr,
    input  logic       rf_avalid,
    output logic       rf_aready,
    output line_t      rf_data,
    output logic       rf_dvalid,
    input  logic       rf_dready
);

    // only written-back lines are stored, the rest read as their fill
    line_t       mem [line_addr_t];
    logic [15:0] lfsr;
    logic        busy;
    line_addr_t  pend_addr;
    logic [1:0]  delay;

    // galois form, taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // word k of line l holds l + k
    function automatic line_t fill_line(input line_addr_t l);
        line_t v;
        for (int k = 0; k < WORDS_PER_LINE; k++) begin
            v[k*WORD_W +: WORD_W] = word_t'(l) + word_t'(k);
        end
        return v;
    endfunction

    initial begin
        lfsr = 16'd48;
        busy      <= 1'b0;
        delay     <= '0;
        pend_addr <= '0;
        wb_ready  <= 1'b0;
        rf_aready <= 1'b0;
        rf_data   <= '0;
        rf_dvalid <= 1'b0;
        forever begin
            @(posedge clk);
            if (rst) begin
                busy      <= 1'b0;
                wb_ready  <= 1'b0;
                rf_aready <= 1'b0;
                rf_dvalid <= 1'b0;
            end else begin
                // one lfsr step per random bit
                wb_ready <= lfsr[0];
                lfsr = lfsr_next(lfsr);
                rf_aready <= lfsr[0] && !busy;
                lfsr = lfsr_next(lfsr);
                if (wb_valid && wb_ready) begin
                    mem[wb_addr] = wb_data;
                end
                if (rf_avalid && rf_aready) begin
                    busy      <= 1'b1;
                    pend_addr <= rf_addr;
                    delay[0]  <= lfsr[0];
                    lfsr = lfsr_next(lfsr);
                    delay[1]  <= lfsr[0];
                    lfsr = lfsr_next(lfsr);
                end else if (busy && !rf_dvalid) begin
                    if (delay == '0) begin
                        rf_dvalid <= 1'b1;
                        rf_data   <= mem.exists(pend_addr) ? mem[pend_addr]
                                                           : fill_line(pend_addr);
                    end else begin
                        delay <= delay - 1'b1;
                    end
                end else if (rf_dvalid && rf_dready) begin
                    rf_dvalid <= 1'b0;
                    busy      <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic clk
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #20;
            clk = ~clk;
        end
    end

endmodule

`default_nettype wire
